/* verilog/sd_cmd_pkg.sv */
package sd_cmd_pkg;

    // register port
    localparam int REG_ADDR_W  = 3;
    localparam int ARG_W       = 32;
    localparam int CMD_INDEX_W = 6;
    localparam int RESP_TYPE_W = 2;
    localparam int CMD_REG_W   = 12;

    // command register fields
    localparam int CMD_FIELD_INDEX_LSB = 0;
    localparam int CMD_FIELD_RESP_LSB  = 8;
    localparam int CMD_FIELD_CRC_CHK   = 10;
    localparam int CMD_FIELD_IDX_CHK   = 11;

    // status bits, write 1 to clear
    localparam int INT_W             = 4;
    localparam int INT_CMD_COMPLETE  = 0;
    localparam int INT_CMD_TIMEOUT   = 1;
    localparam int INT_CMD_CRC_ERR   = 2;
    localparam int INT_CMD_INDEX_ERR = 3;

    // cmd line framing
    localparam int FRAME_W    = 48;
    localparam int CRC_W      = 7;
    localparam int CRC_SPAN_W = 40;
    localparam int BIT_CNT_W  = 6;
    localparam int NCR_MAX    = 64;
    localparam int NCR_CNT_W  = $clog2(NCR_MAX);

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_ARGUMENT      = 3'd0,
        REG_COMMAND       = 3'd1,
        REG_RESPONSE      = 3'd2,
        REG_INT_STATUS    = 3'd3,
        REG_INT_ENABLE    = 3'd4,
        REG_PRESENT_STATE = 3'd5
    } reg_addr_e;

    // codes 2 and 3 are reserved and behave like RESP_NONE
    typedef enum logic [RESP_TYPE_W-1:0] {
        RESP_NONE  = 2'd0,
        RESP_SHORT = 2'd1
    } resp_type_e;

endpackage

/* verilog/sd_cmd_regs.sv */
`timescale 1ns/1ps

module sd_cmd_regs (
    input  logic                                 sd_clk,
    input  logic                                 reset_i,
    input  logic                                 wr_en_i,
    input  logic                                 rd_en_i,
    input  sd_cmd_pkg::reg_addr_e                addr_i,
    input  logic [sd_cmd_pkg::ARG_W-1:0]         wr_data_i,
    output logic [sd_cmd_pkg::ARG_W-1:0]         rd_data_o,
    output logic                                 interrupt_o,
    output logic                                 cmd_start_o,
    output logic [sd_cmd_pkg::ARG_W-1:0]         argument_o,
    output logic [sd_cmd_pkg::CMD_INDEX_W-1:0]   cmd_index_o,
    output sd_cmd_pkg::resp_type_e               resp_type_o,
    output logic                                 crc_check_en_o,
    output logic                                 index_check_en_o,
    input  logic                                 cmd_inhibit_i,
    input  logic                                 done_i,
    input  logic [sd_cmd_pkg::INT_W-1:0]         status_set_i,
    input  logic [sd_cmd_pkg::ARG_W-1:0]         response_i
);
    import sd_cmd_pkg::*;

    logic [CMD_REG_W-1:0] command_q;
    logic [ARG_W-1:0]     response_q;
    logic [INT_W-1:0]     int_enable_q;
    logic [INT_W-1:0]     int_status_q;
    logic [INT_W-1:0]     status_clr;
    logic                 cmd_wr_ok;

    // a command write only counts while the sequencer is free
    assign cmd_wr_ok = wr_en_i && (addr_i == REG_COMMAND) && !cmd_inhibit_i && !cmd_start_o;

    assign status_clr = (wr_en_i && (addr_i == REG_INT_STATUS)) ?
                        wr_data_i[INT_W-1:0] : '0;

    // command field decode
    assign cmd_index_o      = command_q[CMD_FIELD_INDEX_LSB +: CMD_INDEX_W];
    assign resp_type_o      = resp_type_e'(command_q[CMD_FIELD_RESP_LSB +: RESP_TYPE_W]);
    assign crc_check_en_o   = command_q[CMD_FIELD_CRC_CHK];
    assign index_check_en_o = command_q[CMD_FIELD_IDX_CHK];

    assign interrupt_o = |(int_status_q & int_enable_q);

    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            cmd_start_o  <= 1'b0;
            argument_o   <= '0;
            command_q    <= '0;
            response_q   <= '0;
            int_enable_q <= '0;
            int_status_q <= '0;
        end else begin
            cmd_start_o <= cmd_wr_ok;
            if (wr_en_i && (addr_i == REG_ARGUMENT)) begin
                argument_o <= wr_data_i;
            end
            if (cmd_wr_ok) begin
                command_q <= wr_data_i[CMD_REG_W-1:0];
            end
            if (wr_en_i && (addr_i == REG_INT_ENABLE)) begin
                int_enable_q <= wr_data_i[INT_W-1:0];
            end
            if (done_i) begin
                response_q <= response_i;
            end
            // set has priority over a clear in the same cycle
            int_status_q <= (int_status_q & ~status_clr) | (done_i ? status_set_i : '0);
        end
    end

    // registered read port
    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            case (addr_i)
                REG_ARGUMENT:      rd_data_o <= argument_o;
                REG_COMMAND:       rd_data_o <= {{(ARG_W-CMD_REG_W){1'b0}}, command_q};
                REG_RESPONSE:      rd_data_o <= response_q;
                REG_INT_STATUS:    rd_data_o <= {{(ARG_W-INT_W){1'b0}}, int_status_q};
                REG_INT_ENABLE:    rd_data_o <= {{(ARG_W-INT_W){1'b0}}, int_enable_q};
                REG_PRESENT_STATE: rd_data_o <= {{(ARG_W-1){1'b0}}, cmd_inhibit_i};
                default:           rd_data_o <= '0;
            endcase
        end
    end

endmodule

/* verilog/sd_cmd_master.sv */
`timescale 1ns/1ps

module sd_cmd_master (
    input  logic                                 sd_clk,
    input  logic                                 reset_i,
    input  logic                                 cmd_start_i,
    input  logic [sd_cmd_pkg::ARG_W-1:0]         argument_i,
    input  logic [sd_cmd_pkg::CMD_INDEX_W-1:0]   cmd_index_i,
    input  sd_cmd_pkg::resp_type_e               resp_type_i,
    input  logic                                 crc_check_en_i,
    input  logic                                 index_check_en_i,
    output logic                                 cmd_inhibit_o,
    output logic                                 done_o,
    output logic [sd_cmd_pkg::INT_W-1:0]         status_set_o,
    output logic [sd_cmd_pkg::ARG_W-1:0]         response_o,
    output logic                                 xfr_start_o,
    output logic [sd_cmd_pkg::ARG_W-1:0]         xfr_argument_o,
    output logic [sd_cmd_pkg::CMD_INDEX_W-1:0]   xfr_index_o,
    output logic                                 expect_response_o,
    input  logic                                 finish_i,
    input  logic                                 timeout_i,
    input  logic                                 crc_ok_i,
    input  logic [sd_cmd_pkg::CMD_INDEX_W-1:0]   rx_index_i,
    input  logic [sd_cmd_pkg::ARG_W-1:0]         rx_argument_i
);
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_FINISH
    } state_e;

    state_e           state;
    logic             crc_chk_q;
    logic             idx_chk_q;
    logic             resp_valid;
    logic             crc_err;
    logic             idx_err;
    logic [INT_W-1:0] status_next;

    assign xfr_start_o = (state == SEND);

    // stays high through the done cycle so status lands before inhibit drops
    assign cmd_inhibit_o = (state != IDLE) || done_o;

    // response fields only mean something when a reply actually arrived
    assign resp_valid = expect_response_o && !timeout_i;
    assign crc_err    = resp_valid && crc_chk_q && !crc_ok_i;
    assign idx_err    = resp_valid && idx_chk_q && (rx_index_i != xfr_index_o);

    always_comb begin
        status_next                    = '0;
        status_next[INT_CMD_COMPLETE]  = 1'b1;
        status_next[INT_CMD_TIMEOUT]   = expect_response_o && timeout_i;
        status_next[INT_CMD_CRC_ERR]   = crc_err;
        status_next[INT_CMD_INDEX_ERR] = idx_err;
    end

    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            state             <= IDLE;
            done_o            <= 1'b0;
            expect_response_o <= 1'b0;
            crc_chk_q         <= 1'b0;
            idx_chk_q         <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_start_i) begin
                        // reserved response codes fall back to no response
                        expect_response_o <= (resp_type_i == RESP_SHORT);
                        crc_chk_q         <= crc_check_en_i;
                        idx_chk_q         <= index_check_en_i;
                        state             <= SEND;
                    end
                end
                SEND: begin
                    state <= WAIT_FINISH;
                end
                WAIT_FINISH: begin
                    if (finish_i) begin
                        done_o <= 1'b1;
                        state  <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // frame fields and outcome
    always_ff @(posedge sd_clk) begin
        if ((state == IDLE) && cmd_start_i) begin
            xfr_argument_o <= argument_i;
            xfr_index_o    <= cmd_index_i;
        end
        if ((state == WAIT_FINISH) && finish_i) begin
            status_set_o <= status_next;
            response_o   <= resp_valid ? rx_argument_i : '0;
        end
    end

endmodule

/* verilog/sd_cmd_serial_host.sv */
`timescale 1ns/1ps

module sd_cmd_serial_host (
    input  logic                                 sd_clk,
    input  logic                                 reset_i,
    input  logic                                 xfr_start_i,
    input  logic [sd_cmd_pkg::ARG_W-1:0]         xfr_argument_i,
    input  logic [sd_cmd_pkg::CMD_INDEX_W-1:0]   xfr_index_i,
    input  logic                                 expect_response_i,
    output logic                                 finish_o,
    output logic                                 timeout_o,
    output logic                                 crc_ok_o,
    output logic [sd_cmd_pkg::CMD_INDEX_W-1:0]   rx_index_o,
    output logic [sd_cmd_pkg::ARG_W-1:0]         rx_argument_o,
    input  logic                                 sd_cmd_i,
    output logic                                 sd_cmd_o,
    output logic                                 sd_cmd_oe_o
);
    import sd_cmd_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        TX,
        WAIT_RESP,
        RX,
        FINISH
    } state_e;

    state_e                state;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [NCR_CNT_W-1:0]  ncr_cnt;
    logic [CRC_W-1:0]      crc;
    logic                  expect_q;
    logic [CRC_SPAN_W-1:0] tx_data;
    logic [FRAME_W-2:0]    rx_data;

    // one step of crc7, polynomial x^7 + x^3 + 1
    function automatic logic [CRC_W-1:0] crc7_step(input logic [CRC_W-1:0] crc_in,
                                                   input logic din);
        logic fb;
        fb = din ^ crc_in[CRC_W-1];
        return {crc_in[5:3], crc_in[2] ^ fb, crc_in[1:0], fb};
    endfunction

    assign finish_o = (state == FINISH);

    // rx_data holds the 47 bits that follow the start bit
    assign rx_index_o    = rx_data[FRAME_W-3 -: CMD_INDEX_W];
    assign rx_argument_o = rx_data[CRC_W+1 +: ARG_W];
    assign crc_ok_o      = (crc == rx_data[CRC_W:1]);

    always_ff @(posedge sd_clk) begin
        if (reset_i) begin
            state       <= IDLE;
            bit_cnt     <= '0;
            ncr_cnt     <= '0;
            crc         <= '0;
            expect_q    <= 1'b0;
            timeout_o   <= 1'b0;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (xfr_start_i) begin
                        // start bit goes out now, a zero bit leaves crc at zero
                        sd_cmd_o    <= 1'b0;
                        sd_cmd_oe_o <= 1'b1;
                        crc         <= '0;
                        bit_cnt     <= BIT_CNT_W'(1);
                        timeout_o   <= 1'b0;
                        expect_q    <= expect_response_i;
                        state       <= TX;
                    end
                end
                TX: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt < BIT_CNT_W'(CRC_SPAN_W)) begin
                        sd_cmd_o <= tx_data[CRC_SPAN_W-1];
                        crc      <= crc7_step(crc, tx_data[CRC_SPAN_W-1]);
                    end else if (bit_cnt < BIT_CNT_W'(FRAME_W-1)) begin
                        sd_cmd_o <= crc[CRC_W-1];
                        crc      <= {crc[CRC_W-2:0], 1'b0};
                    end else begin
                        // end bit
                        sd_cmd_o <= 1'b1;
                        ncr_cnt  <= '0;
                        state    <= expect_q ? WAIT_RESP : FINISH;
                    end
                end
                WAIT_RESP: begin
                    sd_cmd_oe_o <= 1'b0;
                    sd_cmd_o    <= 1'b1;
                    if (!sd_cmd_i) begin
                        crc     <= '0;
                        bit_cnt <= BIT_CNT_W'(1);
                        state   <= RX;
                    end else if (ncr_cnt == NCR_CNT_W'(NCR_MAX-1)) begin
                        timeout_o <= 1'b1;
                        state     <= FINISH;
                    end else begin
                        ncr_cnt <= ncr_cnt + 1'b1;
                    end
                end
                RX: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt < BIT_CNT_W'(CRC_SPAN_W)) begin
                        crc <= crc7_step(crc, sd_cmd_i);
                    end
                    if (bit_cnt == BIT_CNT_W'(FRAME_W-1)) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    sd_cmd_oe_o <= 1'b0;
                    sd_cmd_o    <= 1'b1;
                    state       <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // shift registers for the outgoing header and the incoming frame
    always_ff @(posedge sd_clk) begin
        if ((state == IDLE) && xfr_start_i) begin
            tx_data <= {1'b1, xfr_index_i, xfr_argument_i, 1'b0};
        end else if ((state == TX) && (bit_cnt < BIT_CNT_W'(CRC_SPAN_W))) begin
            tx_data <= {tx_data[CRC_SPAN_W-2:0], 1'b0};
        end
        if (state == RX) begin
            rx_data <= {rx_data[FRAME_W-3:0], sd_cmd_i};
        end
    end

endmodule

/* verilog/sd_emmc_cmd_top.sv */
`timescale 1ns/1ps

module sd_emmc_cmd_top (
    input  logic                         sd_clk,
    input  logic                         reset_i,
    input  logic                         wr_en_i,
    input  logic                         rd_en_i,
    input  sd_cmd_pkg::reg_addr_e        addr_i,
    input  logic [sd_cmd_pkg::ARG_W-1:0] wr_data_i,
    output logic [sd_cmd_pkg::ARG_W-1:0] rd_data_o,
    output logic                         interrupt_o,
    input  logic                         sd_cmd_i,
    output logic                         sd_cmd_o,
    output logic                         sd_cmd_oe_o
);
    import sd_cmd_pkg::*;

    // register block to sequencer
    logic                   cmd_start;
    logic [ARG_W-1:0]       argument;
    logic [CMD_INDEX_W-1:0] cmd_index;
    resp_type_e             resp_type;
    logic                   crc_check_en;
    logic                   index_check_en;

    // sequencer back to registers
    logic                   cmd_inhibit;
    logic                   done_pulse;
    logic [INT_W-1:0]       status_set;
    logic [ARG_W-1:0]       response;

    // sequencer and serializer
    logic                   xfr_start;
    logic [ARG_W-1:0]       xfr_argument;
    logic [CMD_INDEX_W-1:0] xfr_index;
    logic                   expect_response;
    logic                   finish;
    logic                   timeout;
    logic                   crc_ok;
    logic [CMD_INDEX_W-1:0] rx_index;
    logic [ARG_W-1:0]       rx_argument;

    sd_cmd_regs u_regs (
        .sd_clk           (sd_clk),
        .reset_i          (reset_i),
        .wr_en_i          (wr_en_i),
        .rd_en_i          (rd_en_i),
        .addr_i           (addr_i),
        .wr_data_i        (wr_data_i),
        .rd_data_o        (rd_data_o),
        .interrupt_o      (interrupt_o),
        .cmd_start_o      (cmd_start),
        .argument_o       (argument),
        .cmd_index_o      (cmd_index),
        .resp_type_o      (resp_type),
        .crc_check_en_o   (crc_check_en),
        .index_check_en_o (index_check_en),
        .cmd_inhibit_i    (cmd_inhibit),
        .done_i           (done_pulse),
        .status_set_i     (status_set),
        .response_i       (response)
    );

    sd_cmd_master u_master (
        .sd_clk            (sd_clk),
        .reset_i           (reset_i),
        .cmd_start_i       (cmd_start),
        .argument_i        (argument),
        .cmd_index_i       (cmd_index),
        .resp_type_i       (resp_type),
        .crc_check_en_i    (crc_check_en),
        .index_check_en_i  (index_check_en),
        .cmd_inhibit_o     (cmd_inhibit),
        .done_o            (done_pulse),
        .status_set_o      (status_set),
        .response_o        (response),
        .xfr_start_o       (xfr_start),
        .xfr_argument_o    (xfr_argument),
        .xfr_index_o       (xfr_index),
        .expect_response_o (expect_response),
        .finish_i          (finish),
        .timeout_i         (timeout),
        .crc_ok_i          (crc_ok),
        .rx_index_i        (rx_index),
        .rx_argument_i     (rx_argument)
    );

    sd_cmd_serial_host u_serial_host (
        .sd_clk            (sd_clk),
        .reset_i           (reset_i),
        .xfr_start_i       (xfr_start),
        .xfr_argument_i    (xfr_argument),
        .xfr_index_i       (xfr_index),
        .expect_response_i (expect_response),
        .finish_o          (finish),
        .timeout_o         (timeout),
        .crc_ok_o          (crc_ok),
        .rx_index_o        (rx_index),
        .rx_argument_o     (rx_argument),
        .sd_cmd_i          (sd_cmd_i),
        .sd_cmd_o          (sd_cmd_o),
        .sd_cmd_oe_o       (sd_cmd_oe_o)
    );

endmodule

/* verif/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model (
    input  logic        clk_i,
    input  logic        cmd_i,
    input  logic [1:0]  reply_mode_i,
    output logic        cmd_o,
    output logic [5:0]  frame_index_o,
    output logic [31:0] frame_arg_o,
    output logic        frame_ok_o,
    output int          frame_count_o
);
    // reply modes
    localparam logic [1:0]  REPLY_NONE      = 2'd0;
    localparam logic [1:0]  REPLY_BAD_CRC   = 2'd2;
    localparam logic [1:0]  REPLY_WRONG_IDX = 2'd3;
    localparam logic [31:0] REPLY_XOR       = 32'hA5A5_0F0F;
    localparam int          REPLY_DELAY     = 8;

    logic [47:0] frame;
    logic [47:0] reply;

    // crc7 over the 40 header bits with x^7 + x^3 + 1
    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    // collect the 47 bits after the start bit
    task automatic receive_frame();
        frame[47] = 1'b0;
        for (int i = 46; i >= 0; i--) begin
            @(negedge clk_i);
            frame[i] = cmd_i;
        end
        frame_index_o = frame[45:40];
        frame_arg_o   = frame[39:8];
        // host frames carry transmission bit 1 and end bit 1
        frame_ok_o    = frame[46] && frame[0] && (frame[7:1] == crc7(frame[47:8]));
        frame_count_o = frame_count_o + 1;
    endtask

    task automatic send_reply(input logic [1:0] mode);
        logic [5:0] index;
        index       = (mode == REPLY_WRONG_IDX) ? frame_index_o + 6'd1 : frame_index_o;
        reply[47:8] = {2'b00, index, frame_arg_o ^ REPLY_XOR};
        reply[7:1]  = crc7(reply[47:8]);
        reply[0]    = 1'b1;
        if (mode == REPLY_BAD_CRC) begin
            reply[1] = ~reply[1];
        end
        repeat (REPLY_DELAY) @(negedge clk_i);
        for (int i = 47; i >= 0; i--) begin
            cmd_o = reply[i];
            @(negedge clk_i);
        end
        cmd_o = 1'b1;
    endtask

    initial begin
        cmd_o         = 1'b1;
        frame_index_o = '0;
        frame_arg_o   = '0;
        frame_ok_o    = 1'b0;
        frame_count_o = 0;
        forever begin
            @(negedge clk_i);
            if (cmd_i === 1'b0) begin
                receive_frame();
                if (reply_mode_i != REPLY_NONE) begin
                    send_reply(reply_mode_i);
                end
            end
        end
    end

endmodule

/* verif/tb_sd_emmc_cmd.sv */
`timescale 1ns/1ps

module tb_sd_emmc_cmd;
    import sd_cmd_pkg::*;

    localparam int          NUM_TESTS   = 10;
    localparam int          TEST_CYCLES = 48 + NCR_MAX + 48 + 40;
    localparam int          CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES;
    localparam logic [31:0] REPLY_XOR   = 32'hA5A5_0F0F;
    // card reply modes
    localparam logic [1:0]  NO_REPLY    = 2'd0;
    localparam logic [1:0]  GOOD        = 2'd1;
    localparam logic [1:0]  BAD_CRC     = 2'd2;
    localparam logic [1:0]  WRONG_IDX   = 2'd3;

    typedef struct packed {
        logic [5:0] index;
        logic [1:0] resp;
        logic       crc_chk;
        logic       idx_chk;
        logic [1:0] reply;
        logic [3:0] enable;
        logic [3:0] status;
    } entry_t;

    logic        sd_clk;
    logic        reset_i;
    logic        wr_en_i;
    logic        rd_en_i;
    reg_addr_e   addr_i;
    logic [31:0] wr_data_i;
    logic [31:0] rd_data_o;
    logic        interrupt_o;
    logic        sd_cmd_o;
    logic        sd_cmd_oe_o;
    logic        card_cmd;
    logic        cmd_line;
    logic [1:0]  reply_mode;
    logic [5:0]  card_index;
    logic [31:0] card_arg;
    logic        card_frame_ok;
    int          card_frames;

    entry_t      table_q [NUM_TESTS];
    integer      seed = 92;
    int          cycles = 0;
    int          errors = 0;
    int          failed_tests = 0;

    // host owns the line while oe is high
    assign cmd_line = sd_cmd_oe_o ? sd_cmd_o : card_cmd;

    sd_emmc_cmd_top DUT (
        .sd_clk      (sd_clk),
        .reset_i     (reset_i),
        .wr_en_i     (wr_en_i),
        .rd_en_i     (rd_en_i),
        .addr_i      (addr_i),
        .wr_data_i   (wr_data_i),
        .rd_data_o   (rd_data_o),
        .interrupt_o (interrupt_o),
        .sd_cmd_i    (cmd_line),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o)
    );

    sd_card_model u_card (
        .clk_i         (sd_clk),
        .cmd_i         (cmd_line),
        .reply_mode_i  (reply_mode),
        .cmd_o         (card_cmd),
        .frame_index_o (card_index),
        .frame_arg_o   (card_arg),
        .frame_ok_o    (card_frame_ok),
        .frame_count_o (card_frames)
    );

    always #2 sd_clk = ~sd_clk;

    always @(posedge sd_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
        wr_en_i   = 1'b1;
        addr_i    = addr;
        wr_data_i = data;
        @(negedge sd_clk);
        wr_en_i   = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
        rd_en_i = 1'b1;
        addr_i  = addr;
        @(negedge sd_clk);
        rd_en_i = 1'b0;
        data    = rd_data_o;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // inhibit has to be seen high first, then low
    task automatic wait_command_done();
        logic [31:0] present;
        logic        busy_seen;
        present   = '0;
        busy_seen = 1'b0;
        while (!(busy_seen && !present[0])) begin
            read_reg(REG_PRESENT_STATE, present);
            busy_seen = busy_seen | present[0];
        end
    endtask

    task automatic check_reset_values();
        logic [31:0] data;
        for (int a = 0; a < 6; a++) begin
            read_reg(reg_addr_e'(a), data);
            check_value($sformatf("register %0d", a), data, 32'd0);
        end
        check_value("interrupt_o", 32'(interrupt_o), 32'd0);
        check_value("sd_cmd_oe_o", 32'(sd_cmd_oe_o), 32'd0);
        check_value("sd_cmd_o", 32'(sd_cmd_o), 32'd1);
        $display("test reset: %s", (errors == 0) ? "passed" : "failed");
        if (errors != 0) begin
            failed_tests = failed_tests + 1;
        end
    endtask

    task automatic run_entry(input int t);
        entry_t      e;
        logic [31:0] arg;
        logic [31:0] command;
        logic [31:0] data;
        int          errors_before;
        int          frames_before;
        e             = table_q[t];
        arg           = $random(seed);
        errors_before = errors;
        frames_before = card_frames;
        command = '0;
        command[CMD_FIELD_INDEX_LSB +: CMD_INDEX_W] = e.index;
        command[CMD_FIELD_RESP_LSB +: 2]            = e.resp;
        command[CMD_FIELD_CRC_CHK]                  = e.crc_chk;
        command[CMD_FIELD_IDX_CHK]                  = e.idx_chk;
        reply_mode = e.reply;
        write_reg(REG_INT_ENABLE, 32'(e.enable));
        write_reg(REG_ARGUMENT, arg);
        write_reg(REG_COMMAND, command);
        @(negedge sd_clk);
        // lands while inhibit is high
        write_reg(REG_COMMAND, command ^ 32'h0000_003F);
        wait_command_done();
        assert ((card_frames == frames_before + 1) && card_frame_ok) else begin
            $display("card did not receive exactly one well formed command frame");
            errors = errors + 1;
        end
        check_value("card index", 32'(card_index), 32'(e.index));
        check_value("card argument", card_arg, arg);
        read_reg(REG_INT_STATUS, data);
        check_value("int_status", data, 32'(e.status));
        check_value("interrupt_o", 32'(interrupt_o), 32'(|(e.status & e.enable)));
        if (e.reply != NO_REPLY) begin
            read_reg(REG_RESPONSE, data);
            check_value("response", data, arg ^ REPLY_XOR);
        end
        read_reg(REG_COMMAND, data);
        check_value("command", data, command);
        read_reg(REG_ARGUMENT, data);
        check_value("argument", data, arg);
        read_reg(REG_INT_ENABLE, data);
        check_value("int_enable", data, 32'(e.enable));
        check_value("sd_cmd_oe_o", 32'(sd_cmd_oe_o), 32'd0);
        // completion first, then whatever is left
        write_reg(REG_INT_STATUS, 32'd1 << INT_CMD_COMPLETE);
        read_reg(REG_INT_STATUS, data);
        check_value("int_status", data, 32'(e.status) & ~(32'd1 << INT_CMD_COMPLETE));
        write_reg(REG_INT_STATUS, 32'h0000_000F);
        read_reg(REG_INT_STATUS, data);
        check_value("int_status", data, 32'd0);
        check_value("interrupt_o", 32'(interrupt_o), 32'd0);
        if (errors != errors_before) begin
            failed_tests = failed_tests + 1;
        end
        $display("test %0d cmd%0d reply mode %0d: %s", t, e.index, e.reply,
                 (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        sd_clk     = 1'b0;
        reset_i    = 1'b1;
        wr_en_i    = 1'b0;
        rd_en_i    = 1'b0;
        addr_i     = REG_ARGUMENT;
        wr_data_i  = '0;
        reply_mode = NO_REPLY;
        // index, resp, crc chk, idx chk, reply, enable, expected status
        table_q[0] = '{6'd0,  RESP_NONE,  1'b0, 1'b0, NO_REPLY,  4'hF, 4'b0001};
        table_q[1] = '{6'd17, RESP_SHORT, 1'b1, 1'b1, GOOD,      4'hF, 4'b0001};
        table_q[2] = '{6'd8,  RESP_SHORT, 1'b1, 1'b0, BAD_CRC,   4'hF, 4'b0101};
        table_q[3] = '{6'd8,  RESP_SHORT, 1'b0, 1'b1, BAD_CRC,   4'hF, 4'b0001};
        table_q[4] = '{6'd55, RESP_SHORT, 1'b1, 1'b1, WRONG_IDX, 4'hF, 4'b1001};
        table_q[5] = '{6'd55, RESP_SHORT, 1'b1, 1'b0, WRONG_IDX, 4'hF, 4'b0001};
        table_q[6] = '{6'd13, RESP_SHORT, 1'b1, 1'b1, NO_REPLY,  4'hF, 4'b0011};
        table_q[7] = '{6'd9,  RESP_SHORT, 1'b1, 1'b1, GOOD,      4'h4, 4'b0001};
        table_q[8] = '{6'd63, 2'd3,       1'b1, 1'b1, NO_REPLY,  4'hF, 4'b0001};
        table_q[9] = '{6'd41, RESP_SHORT, 1'b1, 1'b1, NO_REPLY,  4'h2, 4'b0011};
        repeat (3) @(posedge sd_clk);
        @(negedge sd_clk);
        reset_i = 1'b0;
        check_reset_values();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end
        $display("%0d tests, %0d failed, %0d failed checks",
                 NUM_TESTS + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tb.f */
verilog/sd_cmd_pkg.sv
verilog/sd_cmd_regs.sv
verilog/sd_cmd_master.sv
verilog/sd_cmd_serial_host.sv
verilog/sd_emmc_cmd_top.sv
verif/sd_card_model.sv
verif/tb_sd_emmc_cmd.sv

/* Makefile */
SRCS := $(shell cat tb.f)

obj_dir/Vtb_sd_emmc_cmd: tb.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_sd_emmc_cmd -f tb.f

run: obj_dir/Vtb_sd_emmc_cmd
	./obj_dir/Vtb_sd_emmc_cmd | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
